// File: r5p_soc_pkg.sv
/* Shared data bus widths, vector types, GPIO register map
   and the Wishbone classic request and response structs */

package r5p_soc_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  localparam int unsigned DAW     = 15;       // Data address width, byte address
  localparam int unsigned DDW     = 32;       // Data width
  localparam int unsigned DBW     = DDW/8;    // Byte select width
  localparam int unsigned GW      = 32;       // GPIO pin count
  localparam int unsigned MEM_AW  = 12;       // Memory word address, 4096 words
  localparam int unsigned SEL_BIT = DAW-1;    // Slave select address bit

  typedef logic [DAW-1:0] adr_t;
  typedef logic [DDW-1:0] dat_t;
  typedef logic [DBW-1:0] sel_t;
  typedef logic [GW-1:0]  gpio_t;

  ////////////////////////////////////////
  // GPIO register offsets
  ////////////////////////////////////////

  localparam logic [SEL_BIT-1:0] GPIO_OUT = 'h0;  // Output data, RW
  localparam logic [SEL_BIT-1:0] GPIO_ENA = 'h4;  // Output enable, RW
  localparam logic [SEL_BIT-1:0] GPIO_INP = 'h8;  // Synced input, RO

  // Master to slave
  typedef struct packed {
    logic cyc;   // Cycle in progress
    logic stb;   // Strobe
    logic we;    // Write enable
    adr_t adr;   // Byte address
    sel_t sel;   // Byte lane select
    dat_t dat;   // Write data
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    dat_t dat;   // Read data
    logic ack;   // One cycle acknowledge
  } wb_rsp_t;

endpackage

// File: r5p_soc_dec.sv
/* Data bus decoder, splits one Wishbone master onto memory
   and GPIO slaves by address and merges their responses */

module r5p_soc_dec (
  // System
  input  logic                 clk,
  input  logic                 arst_n,
  // Master side
  input  r5p_soc_pkg::wb_req_t req,
  output r5p_soc_pkg::wb_rsp_t rsp,
  // Data memory slave
  output r5p_soc_pkg::wb_req_t mem_req,
  input  r5p_soc_pkg::wb_rsp_t mem_rsp,
  // GPIO slave
  output r5p_soc_pkg::wb_req_t gpio_req,
  input  r5p_soc_pkg::wb_rsp_t gpio_rsp
);

  import r5p_soc_pkg::*;

  ////////////////////////////////////////
  // Slave select
  ////////////////////////////////////////

  logic [1:0] slv_sel;  // One-hot, [0] memory, [1] GPIO

  // Bit 14 low is memory, high is GPIO
  assign slv_sel = {req.adr[SEL_BIT], ~req.adr[SEL_BIT]};

  // Same request to both, strobe only to the chosen one
  always_comb begin
    mem_req      = req;
    mem_req.stb  = req.stb & slv_sel[0];
    gpio_req     = req;
    gpio_req.stb = req.stb & slv_sel[1];
  end

  ////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////

  // Address held until ack, so select is still valid here
  always_comb begin
    if (slv_sel[1]) begin
      rsp = gpio_rsp;  // GPIO reply
    end else begin
      rsp = mem_rsp;   // Memory reply
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Only one slave may answer at a time
  a_ack_onehot: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(mem_rsp.ack && gpio_rsp.ack)
  ) else $error("both slaves acknowledged in one cycle");

  // Registered ack needs a live cycle one clock earlier
  a_ack_cyc: assert property (
    @(posedge clk) disable iff (!arst_n)
    rsp.ack |-> $past(req.cyc)
  ) else $error("ack without a preceding bus cycle");

endmodule

// File: r5p_soc_mem.sv
/* Data memory Wishbone slave, byte lane writes,
   registered read data and one cycle ack */

module r5p_soc_mem (
  input  logic                 clk,
  input  logic                 arst_n,
  input  r5p_soc_pkg::wb_req_t req,
  output r5p_soc_pkg::wb_rsp_t rsp
);

  import r5p_soc_pkg::*;

  dat_t              mem [0:2**MEM_AW-1];  // Word array
  logic [MEM_AW-1:0] word_adr;             // Word index, adr[13:2]
  logic              req_vld;              // New access this cycle
  logic              ack_q;
  dat_t              rdt_q;

  assign word_adr = req.adr[MEM_AW+1:2];

  // Skip the cycle already being acked
  assign req_vld = req.cyc & req.stb & ~ack_q;

  ////////////////////////////////////////
  // Acknowledge
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_vld;  // Pulse on the edge after strobe
    end
  end

  ////////////////////////////////////////
  // Array access
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req_vld) begin
      if (req.we) begin
        for (int b = 0; b < DBW; b++) begin
          if (req.sel[b]) begin
            mem[word_adr][8*b +: 8] <= req.dat[8*b +: 8];  // Selected lane only
          end
        end
      end else begin
        rdt_q <= mem[word_adr];  // Valid together with ack
      end
    end
  end

  assign rsp = '{dat: rdt_q, ack: ack_q};

  // Ack is a single pulse
  a_ack_pulse: assert property (
    @(posedge clk) disable iff (!arst_n)
    ack_q |=> !ack_q
  ) else $error("memory ack held longer than one cycle");

endmodule

// File: r5p_soc_gpio.sv
/* GPIO controller Wishbone slave with output data, output
   enable and a two flop synchronized input register */

module r5p_soc_gpio (
  // System
  input  logic                 clk,
  input  logic                 arst_n,
  // Bus
  input  r5p_soc_pkg::wb_req_t req,
  output r5p_soc_pkg::wb_rsp_t rsp,
  // Pins
  output r5p_soc_pkg::gpio_t   gpio_o,
  output r5p_soc_pkg::gpio_t   gpio_e,
  input  r5p_soc_pkg::gpio_t   gpio_i
);

  import r5p_soc_pkg::*;

  logic [SEL_BIT-3:0] reg_adr;  // Word offset inside GPIO space
  logic               req_vld;
  logic               wr_out;   // Write to output data
  logic               wr_ena;   // Write to output enable
  gpio_t              out_q;
  gpio_t              ena_q;
  gpio_t              inp_s1;   // First sync stage
  gpio_t              inp_s2;   // Second sync stage, readable
  dat_t               rd_mux;
  dat_t               rdt_q;
  logic               ack_q;

  // Merge write data into a register per byte select
  function automatic gpio_t byte_wr(gpio_t old, dat_t wdt, sel_t sel);
    gpio_t res;
    res = old;
    for (int b = 0; b < DBW; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = wdt[8*b +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign reg_adr = req.adr[SEL_BIT-1:2];
  assign req_vld = req.cyc & req.stb & ~ack_q;                       // Fresh access
  assign wr_out  = req_vld & req.we & (reg_adr == GPIO_OUT[SEL_BIT-1:2]);
  assign wr_ena  = req_vld & req.we & (reg_adr == GPIO_ENA[SEL_BIT-1:2]);

  // Read select, unmapped offsets give zero
  always_comb begin
    if (reg_adr == GPIO_OUT[SEL_BIT-1:2]) begin
      rd_mux = out_q;
    end else if (reg_adr == GPIO_ENA[SEL_BIT-1:2]) begin
      rd_mux = ena_q;
    end else if (reg_adr == GPIO_INP[SEL_BIT-1:2]) begin
      rd_mux = inp_s2;
    end else begin
      rd_mux = '0;
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q  <= 1'b0;
      out_q  <= '0;
      ena_q  <= '0;
      inp_s1 <= '0;
      inp_s2 <= '0;
    end else begin
      ack_q  <= req_vld;  // Every access acked, even unmapped
      inp_s1 <= gpio_i;
      inp_s2 <= inp_s1;
      if (wr_out) out_q <= byte_wr(out_q, req.dat, req.sel);
      if (wr_ena) ena_q <= byte_wr(ena_q, req.dat, req.sel);
    end
  end

  // Read data, no reset
  always_ff @(posedge clk) begin
    if (req_vld && !req.we) begin
      rdt_q <= rd_mux;
    end
  end

  assign rsp    = '{dat: rdt_q, ack: ack_q};
  assign gpio_o = out_q;
  assign gpio_e = ena_q;

endmodule

// File: r5p_soc_top.sv
/* Data bus subsystem top, decoder with the data memory
   and the GPIO controller behind it */

module r5p_soc_top (
  // System
  input  logic                 clk,
  input  logic                 arst_n,
  // External bus master
  input  r5p_soc_pkg::wb_req_t wb_req,
  output r5p_soc_pkg::wb_rsp_t wb_rsp,
  // GPIO pins
  output r5p_soc_pkg::gpio_t   gpio_o,
  output r5p_soc_pkg::gpio_t   gpio_e,
  input  r5p_soc_pkg::gpio_t   gpio_i
);

  import r5p_soc_pkg::*;

  wb_req_t mem_req;   // Decoder to memory
  wb_rsp_t mem_rsp;
  wb_req_t gpio_req;  // Decoder to GPIO
  wb_rsp_t gpio_rsp;

  ////////////////////////////////////////
  // Load/store decoder
  ////////////////////////////////////////

  r5p_soc_dec ls_dec (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (wb_req),
    .rsp      (wb_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .gpio_req (gpio_req),
    .gpio_rsp (gpio_rsp)
  );

  // Data memory, low half of the map
  r5p_soc_mem dmem (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (mem_req),
    .rsp    (mem_rsp)
  );

  // GPIO controller, upper half
  r5p_soc_gpio soc_gpio (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (gpio_req),
    .rsp    (gpio_rsp),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

endmodule

// File: r5p_soc_tb.sv
/* Testbench for the data bus subsystem, runs Wishbone cycles
   from the stimulus file and checks read data and GPIO pins */

module r5p_soc_tb;

  import r5p_soc_pkg::*;

  localparam int N_RND = 64;  // Random fill words

  logic        clk;
  logic        arst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  gpio_t       gpio_o;
  gpio_t       gpio_e;
  gpio_t       gpio_i;
  int          errors    = 0;
  int          n_pass    = 0;
  int          n_fail    = 0;
  int          wd_cycles = 0;   // Set once the stimulus length is known
  logic [31:0] lcg       = 32'h400e_1ad5;
  dat_t        mem_model [int];  // Expected memory words, by word index

  r5p_soc_top dut0 (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .gpio_o (gpio_o),
    .gpio_e (gpio_e),
    .gpio_i (gpio_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // Period 40
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check(input string what, input dat_t exp, input dat_t act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, what, exp, act);
      errors++;
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Byte lanes chosen by sel take the new data
  function automatic dat_t merge_bytes(input dat_t old, input dat_t wdt, input sel_t sel);
    dat_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old & ~mask) | (wdt & mask);
  endfunction

  task automatic bus_cycle(input logic we, input adr_t adr, input sel_t sel,
                           input dat_t wdt, output dat_t rdt);
    int n;
    n = 0;
    @(negedge clk);  // One idle clock between cycles
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: wdt};
    do begin
      @(negedge clk);
      n++;
    end while (!wb_rsp.ack && n < 4);
    if (!wb_rsp.ack) begin
      $display("Bus cycle to address %h got no acknowledge within 4 cycles", adr);
      errors++;
    end
    rdt    = wb_rsp.dat;  // Stable mid cycle
    wb_req = '0;          // Drop cyc and stb
  endtask

  task automatic do_write(input adr_t adr, input sel_t sel, input dat_t wdt);
    dat_t rdt;
    dat_t old;
    int   w;
    w = int'(adr[SEL_BIT-1:2]);
    bus_cycle(1'b1, adr, sel, wdt, rdt);
    if (!adr[SEL_BIT]) begin
      old          = mem_model.exists(w) ? mem_model[w] : '0;
      mem_model[w] = merge_bytes(old, wdt, sel);
    end
  endtask

  task automatic do_read(input adr_t adr, input dat_t expv);
    dat_t rdt;
    int   w;
    w = int'(adr[SEL_BIT-1:2]);
    bus_cycle(1'b0, adr, 4'hf, '0, rdt);
    check($sformatf("read %h", adr), expv, rdt);
    if (!adr[SEL_BIT] && mem_model.exists(w)) begin
      check($sformatf("merged word %h", adr), mem_model[w], rdt);  // Model cross check
    end
  endtask

  // Low 6 word bits are the index, so addresses never collide
  task automatic random_fill();
    adr_t rnd_adr [N_RND];
    dat_t rnd_dat [N_RND];
    for (int i = 0; i < N_RND; i++) begin
      lcg        = lcg_next(lcg);
      rnd_adr[i] = {1'b0, lcg[21:16], 6'(i), 2'b00};
      lcg        = lcg_next(lcg);
      rnd_dat[i] = lcg;
      do_write(rnd_adr[i], 4'hf, rnd_dat[i]);
    end
    for (int i = 0; i < N_RND; i++) begin
      do_read(rnd_adr[i], rnd_dat[i]);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      n_pass++;
      $display("%s: ok", name);
    end else begin
      n_fail++;
      $display("%s: failed", name);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int         fd;
    int         n;
    int         n_lines;
    int         n_test;
    int         err0;
    logic [7:0] kind;
    adr_t       adr;
    sel_t       sel;
    dat_t       dat;
    dat_t       expv;
    string      line;
    arst_n  = 1'b0;  // Inputs idle, reset held
    wb_req  = '0;
    gpio_i  = '0;
    n_lines = 0;
    n_test  = 0;
    fd = $fopen("r5p_soc_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file r5p_soc_stimulus.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) n_lines++;
      $fclose(fd);
      fd = $fopen("r5p_soc_stimulus.txt", "r");
    end
    wd_cycles = n_lines * 10 + N_RND * 2 * 10 + 10;  // Random fill and reset margin
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    err0   = errors;
    check("gpio_o after reset", '0, gpio_o);
    check("gpio_e after reset", '0, gpio_e);
    check("ack after reset", '0, dat_t'(wb_rsp.ack));
    report_test("test 0 reset values", err0);
    while (fd != 0 && !$feof(fd)) begin
      kind = 8'h00;
      n    = $fscanf(fd, "%s", kind);
      if (n != 1) break;
      if (kind == "#") begin
        n = $fgets(line, fd);  // Rest of a comment line
        continue;
      end
      n    = $fscanf(fd, "%h %h %h %h", adr, sel, dat, expv);
      err0 = errors;
      n_test++;
      case (kind)
        "W": do_write(adr, sel, dat);
        "R": do_read(adr, expv);
        "I": begin
          gpio_i = dat;
          repeat (3) @(negedge clk);  // Through both sync flops
        end
        "P": begin
          check("gpio_o pins", dat, gpio_o);
          check("gpio_e pins", expv, gpio_e);
        end
        "X": random_fill();
        default: begin
          $display("Unknown operation %s in the stimulus file", kind);
          errors++;
        end
      endcase
      report_test($sformatf("test %0d %s %h", n_test, kind, adr), err0);
    end
    $display("Summary: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog, limit known after the stimulus is counted
  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run stopped", wd_cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: r5p_soc_stimulus.txt
# kind adr sel data expected, all hex after the kind
# W write, R read, I set gpio_i, P check gpio_o (data) and gpio_e (expected), X random fill
W 0000 f deadbeef 00000000
R 0000 f 00000000 deadbeef
W 0004 f 11223344 00000000
W 0004 1 000000aa 00000000
W 0004 4 00550000 00000000
R 0004 f 00000000 115533aa
W 0008 f ffffffff 00000000
W 0008 a 12345678 00000000
R 0008 f 00000000 12ff56ff
W 3ffc f 5a5a5a5a 00000000
R 3ffc f 00000000 5a5a5a5a
# GPIO output and enable registers
W 4000 f a5a5a5a5 00000000
W 4004 f 0000ffff 00000000
P 0000 0 a5a5a5a5 0000ffff
R 4000 f 00000000 a5a5a5a5
R 4004 f 00000000 0000ffff
W 4000 2 00003c00 00000000
R 4000 f 00000000 a5a53ca5
W 4008 f ffffffff 00000000
R 4008 f 00000000 00000000
P 0000 0 a5a53ca5 0000ffff
R 400c f 00000000 00000000
I 0000 0 89abcdef 00000000
R 4008 f 00000000 89abcdef
I 0000 0 00000001 00000000
R 4008 f 00000000 00000001
# Slaves kept apart by address bit 14
W 0000 f 0badf00d 00000000
W 4000 f 77777777 00000000
R 0000 f 00000000 0badf00d
W 0004 f 99999999 00000000
P 0000 0 77777777 0000ffff
R 4004 f 00000000 0000ffff
R 0004 f 00000000 99999999
X 0000 0 00000000 00000000

// File: r5p_soc.f
r5p_soc_pkg.sv
r5p_soc_dec.sv
r5p_soc_mem.sv
r5p_soc_gpio.sv
r5p_soc_top.sv
r5p_soc_tb.sv

// File: Makefile
SIM    := verilator
FLAGS  := --binary --timing --assert
TOP    := r5p_soc_tb
FLIST  := r5p_soc.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
